// File: design/dmni_pkg.sv
package dmni_pkg;

    typedef logic [31:0] word_t;

    localparam word_t WORD_BYTES = 32'd4; // address step per word

    typedef enum logic {
        OP_SEND    = 1'b0,
        OP_RECEIVE = 1'b1
    } dma_op_e;

    // sizes count words, addr_2/size_2 only matter for send
    typedef struct packed {
        logic    start;
        dma_op_e op;
        word_t   addr;
        word_t   size;
        word_t   addr_2;
        word_t   size_2;
    } dma_cfg_t;

    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef enum logic {
        SRC_SEND    = 1'b0,
        SRC_RECEIVE = 1'b1
    } arb_src_e;

    typedef enum logic {
        SEND_IDLE,
        SEND_DATA
    } send_state_e;

    typedef enum logic [1:0] {
        RECV_HEADER,
        RECV_SIZE,
        RECV_WAIT,
        RECV_DATA
    } recv_state_e;

endpackage

// File: design/dmni_send.sv
module dmni_send (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  dmni_pkg::dma_cfg_t cfg_i,
    input  logic               noc_ack_i,
    input  dmni_pkg::word_t    mem_data_i,
    input  logic               grant_i,
    output logic               noc_tx_o,
    output dmni_pkg::word_t    noc_data_o,
    output dmni_pkg::mem_req_t req_o,
    output logic               active_o
);
    import dmni_pkg::*;

    send_state_e state_q;
    send_state_e state_d;

    word_t addr_1_q;
    word_t addr_2_q;
    word_t size_1_q;
    word_t size_2_q;

    logic consume;
    logic use_buf_1;
    logic last_word;
    logic bufs_empty;

    assign consume    = (state_q == SEND_DATA) && grant_i && noc_ack_i;
    assign use_buf_1  = (size_1_q != '0);
    assign bufs_empty = (size_1_q == '0) && (size_2_q == '0);
    assign last_word  = consume && ((size_1_q == 32'd1 && size_2_q == '0)
                                 || (size_1_q == '0 && size_2_q == 32'd1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            SEND_IDLE: begin
                if (cfg_i.start && cfg_i.op == OP_SEND) begin
                    state_d = SEND_DATA;
                end
            end
            SEND_DATA: begin
                if (last_word || bufs_empty) begin // nothing left to fetch
                    state_d = SEND_IDLE;
                end
            end
            default: state_d = SEND_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= SEND_IDLE;
            size_1_q <= '0;
            size_2_q <= '0;
            noc_tx_o <= 1'b0;
        end else begin
            state_q  <= state_d;
            noc_tx_o <= consume; // data shows up a cycle after the fetch
            if (state_q == SEND_IDLE) begin
                size_1_q <= cfg_i.size;
                size_2_q <= cfg_i.size_2;
            end else if (consume) begin
                if (use_buf_1) size_1_q <= size_1_q - 32'd1;
                else           size_2_q <= size_2_q - 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == SEND_IDLE) begin
            addr_1_q <= cfg_i.addr;
            addr_2_q <= cfg_i.addr_2;
        end else if (consume) begin
            if (use_buf_1) addr_1_q <= addr_1_q + WORD_BYTES;
            else           addr_2_q <= addr_2_q + WORD_BYTES;
        end
    end

    assign req_o.we    = 1'b0; // read only
    assign req_o.addr  = use_buf_1 ? addr_1_q : addr_2_q;
    assign req_o.wdata = '0;

    assign noc_data_o = mem_data_i;
    assign active_o   = (state_q == SEND_DATA);

endmodule

// File: design/dmni_receive.sv
module dmni_receive (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  dmni_pkg::dma_cfg_t cfg_i,
    input  logic               noc_rx_i,
    input  dmni_pkg::word_t    noc_data_i,
    input  logic               grant_i,
    output logic               noc_credit_o,
    output dmni_pkg::mem_req_t req_o,
    output logic               active_o,
    output logic               available_o,
    output dmni_pkg::word_t    flits_left_o
);
    import dmni_pkg::*;

    recv_state_e state_q;
    recv_state_e state_d;

    word_t payload_cnt_q; // flits still owed by the packet
    word_t size_q;        // room left in the current buffer
    word_t addr_q;

    logic accept;
    logic start_recv;

    assign accept     = (state_q == RECV_DATA) && noc_rx_i && grant_i;
    assign start_recv = cfg_i.start && (cfg_i.op == OP_RECEIVE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RECV_HEADER: begin
                if (noc_rx_i) state_d = RECV_SIZE;
            end
            RECV_SIZE: begin
                if (noc_rx_i) state_d = RECV_WAIT;
            end
            RECV_WAIT: begin
                if (start_recv) state_d = RECV_DATA;
            end
            RECV_DATA: begin
                if (accept) begin
                    if (payload_cnt_q == 32'd1) begin
                        state_d = RECV_HEADER;
                    end else if (size_q == 32'd1) begin
                        state_d = RECV_WAIT; // buffer full, rest of packet pending
                    end
                end
            end
            default: state_d = RECV_HEADER;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q       <= RECV_HEADER;
            payload_cnt_q <= '0;
            size_q        <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == RECV_SIZE && noc_rx_i) begin
                payload_cnt_q <= noc_data_i;
            end else if (accept) begin
                payload_cnt_q <= payload_cnt_q - 32'd1;
            end
            if (state_q == RECV_WAIT && start_recv) begin
                size_q <= cfg_i.size;
            end else if (accept) begin
                size_q <= size_q - 32'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RECV_WAIT && start_recv) begin
            addr_q <= cfg_i.addr;
        end else if (accept) begin
            addr_q <= addr_q + WORD_BYTES;
        end
    end

    always_comb begin
        case (state_q)
            RECV_HEADER, RECV_SIZE: noc_credit_o = 1'b1;
            RECV_DATA:              noc_credit_o = grant_i; // only while we own memory
            default:                noc_credit_o = 1'b0;
        endcase
    end

    assign req_o.we    = (state_q == RECV_DATA);
    assign req_o.addr  = addr_q;
    assign req_o.wdata = noc_data_i;

    assign active_o     = (state_q == RECV_DATA);
    assign available_o  = (state_q == RECV_WAIT);
    assign flits_left_o = payload_cnt_q;

endmodule

// File: design/dmni_arbiter.sv
module dmni_arbiter #(
    parameter int unsigned SLICE_CYCLES = 15
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  dmni_pkg::mem_req_t send_req_i,
    input  dmni_pkg::mem_req_t recv_req_i,
    input  logic               send_active_i,
    input  logic               recv_active_i,
    output logic               send_grant_o,
    output logic               recv_grant_o,
    output logic [3:0]         mem_we_o,
    output dmni_pkg::word_t    mem_addr_o,
    output dmni_pkg::word_t    mem_data_o
);
    import dmni_pkg::*;

    localparam int TW = $clog2(SLICE_CYCLES + 1);
    localparam logic [TW-1:0] SLICE_LOAD = TW'(SLICE_CYCLES);

    arb_src_e grant_q;
    arb_src_e next_src;
    arb_src_e other_src;

    logic [1:0]    active;
    logic [TW-1:0] timer_q;
    logic          rearb;
    mem_req_t      req;

    assign active    = {recv_active_i, send_active_i}; // indexed by arb_src_e
    assign other_src = (grant_q == SRC_SEND) ? SRC_RECEIVE : SRC_SEND;
    assign next_src  = active[other_src] ? other_src : grant_q;

    // slice used up or holder went idle
    assign rearb = (active != '0) && ((timer_q == '0) || !active[grant_q]);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            grant_q <= SRC_SEND;
            timer_q <= '0;
        end else if (rearb) begin
            grant_q <= next_src;
            timer_q <= SLICE_LOAD;
        end else if (timer_q != '0) begin
            timer_q <= timer_q - TW'(1);
        end
    end

    assign req = (grant_q == SRC_SEND) ? send_req_i : recv_req_i;

    assign mem_we_o   = {4{active[grant_q] && req.we}};
    assign mem_addr_o = req.addr;
    assign mem_data_o = req.wdata;

    assign send_grant_o = (grant_q == SRC_SEND);
    assign recv_grant_o = (grant_q == SRC_RECEIVE);

endmodule

// File: design/dmni_top.sv
module dmni_top #(
    parameter int unsigned SLICE_CYCLES = 15
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               noc_rx_i,
    input  dmni_pkg::word_t    noc_data_i,
    output logic               noc_credit_o,
    output logic               noc_tx_o,
    input  logic               noc_ack_i,
    output dmni_pkg::word_t    noc_data_o,
    output logic [3:0]         mem_we_o,
    output dmni_pkg::word_t    mem_addr_o,
    output dmni_pkg::word_t    mem_data_o,
    input  dmni_pkg::word_t    mem_data_i,
    input  dmni_pkg::dma_cfg_t cfg_i,
    output logic               send_active_o,
    output logic               recv_active_o,
    output logic               recv_available_o,
    output dmni_pkg::word_t    recv_flits_left_o
);
    import dmni_pkg::*;

    mem_req_t send_req;
    mem_req_t recv_req;
    logic     send_grant;
    logic     recv_grant;

    dmni_send u_dmni_send (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .cfg_i      (cfg_i),
        .noc_ack_i  (noc_ack_i),
        .mem_data_i (mem_data_i),
        .grant_i    (send_grant),
        .noc_tx_o   (noc_tx_o),
        .noc_data_o (noc_data_o),
        .req_o      (send_req),
        .active_o   (send_active_o)
    );

    dmni_receive u_dmni_receive (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cfg_i        (cfg_i),
        .noc_rx_i     (noc_rx_i),
        .noc_data_i   (noc_data_i),
        .grant_i      (recv_grant),
        .noc_credit_o (noc_credit_o),
        .req_o        (recv_req),
        .active_o     (recv_active_o),
        .available_o  (recv_available_o),
        .flits_left_o (recv_flits_left_o)
    );

    dmni_arbiter #(
        .SLICE_CYCLES (SLICE_CYCLES)
    ) u_dmni_arbiter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .send_req_i    (send_req),
        .recv_req_i    (recv_req),
        .send_active_i (send_active_o),
        .recv_active_i (recv_active_o),
        .send_grant_o  (send_grant),
        .recv_grant_o  (recv_grant),
        .mem_we_o      (mem_we_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_o    (mem_data_o)
    );

endmodule

// File: dv/tb_mem.sv
module tb_mem #(
    parameter int DEPTH = 256
) (
    input  logic            clk_i,
    input  logic [3:0]      we_i,
    input  dmni_pkg::word_t addr_i,
    input  dmni_pkg::word_t wdata_i,
    output dmni_pkg::word_t rdata_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import dmni_pkg::*;

    localparam int AW = $clog2(DEPTH);

    word_t         mem [DEPTH];
    logic [AW-1:0] idx;

    assign idx = addr_i[AW+1:2]; // upper address bits ignored

    always @(posedge clk_i) begin
        rdata_o <= mem[idx]; // old word on a same-cycle write
        for (int b = 0; b < 4; b++) begin
            if (we_i[b]) begin
                mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
            end
        end
    end

endmodule

// File: dv/tb_dmni.sv
module tb_dmni;
    timeunit 1ns;
    timeprecision 100ps;
    import dmni_pkg::*;

    localparam int DEPTH   = 256;
    localparam int AW      = $clog2(DEPTH);
    localparam int TIMEOUT = 400;

    logic       clk_i;
    logic       rst_ni;
    logic       noc_rx_i;
    word_t      noc_data_i;
    logic       noc_credit_o;
    logic       noc_tx_o;
    logic       noc_ack_i;
    word_t      noc_data_o;
    logic [3:0] mem_we_o;
    word_t      mem_addr_o;
    word_t      mem_data_o;
    word_t      mem_data_i;
    dma_cfg_t   cfg_i;
    logic       send_active_o;
    logic       recv_active_o;
    logic       recv_available_o;
    word_t      recv_flits_left_o;

    word_t lcg_state = 32'h9a7500bd;
    word_t ref_mem [DEPTH]; // reference image of the memory
    word_t exp_flits [$];
    word_t payload_q [$];
    word_t exp_w;

    dmni_top #(.SLICE_CYCLES(15)) u_dmni_top (.*);

    tb_mem #(.DEPTH(DEPTH)) u_mem (
        .clk_i   (clk_i),
        .we_i    (mem_we_o),
        .addr_i  (mem_addr_o),
        .wdata_i (mem_data_o),
        .rdata_o (mem_data_i)
    );

    function automatic word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t ref_read(input word_t addr);
        return ref_mem[addr[AW+1:2]];
    endfunction

    // buffer 1 first, then buffer 2
    function automatic void expect_send(input word_t a1, input word_t s1,
                                        input word_t a2, input word_t s2);
        for (word_t i = 0; i < s1; i++) begin
            exp_flits.push_back(ref_read(a1 + i * WORD_BYTES));
        end
        for (word_t i = 0; i < s2; i++) begin
            exp_flits.push_back(ref_read(a2 + i * WORD_BYTES));
        end
    endfunction

    function automatic void expect_receive(input word_t addr, input int first, input int count);
        word_t a;
        a = addr;
        for (int k = first; k < first + count; k++) begin
            ref_mem[a[AW+1:2]] = payload_q[k];
            a = a + WORD_BYTES;
        end
    endfunction

    function automatic void make_payload(input int n);
        payload_q.delete();
        for (int k = 0; k < n; k++) begin
            payload_q.push_back(next_rand());
        end
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_fail(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic timeout_fail(input string what);
        $display("timed out waiting: %s", what);
        stop_run();
    endtask

    task automatic pulse_cfg(input dma_op_e op, input word_t a1, input word_t s1,
                             input word_t a2, input word_t s2);
        @(posedge clk_i);
        #1;
        cfg_i = '{start: 1'b1, op: op, addr: a1, size: s1, addr_2: a2, size_2: s2};
        @(posedge clk_i);
        #1;
        cfg_i.start = 1'b0;
    endtask

    // holds the flit until a cycle with credit high
    task automatic send_flit(input word_t w);
        int n;
        n = 0;
        noc_rx_i   = 1'b1;
        noc_data_i = w;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) timeout_fail("no credit on the receive link");
        end while (!noc_credit_o);
        @(posedge clk_i);
        #1;
        noc_rx_i = 1'b0;
    endtask

    task automatic send_packet(input int n);
        @(posedge clk_i);
        #1;
        send_flit(32'h0000_0001); // header
        send_flit(word_t'(n));
        for (int k = 0; k < n; k++) begin
            send_flit(payload_q[k]);
        end
    endtask

    task automatic run_send(input logic random_ack);
        word_t r;
        int    n;
        n = 0;
        do begin
            @(posedge clk_i);
            #1;
            r = next_rand();
            noc_ack_i = random_ack ? r[28] : 1'b1;
            n++;
            if (n > TIMEOUT) timeout_fail("send engine never went idle");
        end while (send_active_o);
        noc_ack_i = 1'b1;
        @(posedge clk_i); // last flit leaves a cycle after the last fetch
        #1;
        assert (exp_flits.size() == 0)
            else check_fail($sformatf("%0d flits missing on the send link", exp_flits.size()));
    endtask

    task automatic wait_available();
        int n;
        n = 0;
        do begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT) timeout_fail("receive engine never asked for a buffer");
        end while (!recv_available_o);
    endtask

    task automatic check_memory();
        for (int i = 0; i < DEPTH; i++) begin
            assert (u_mem.mem[i] == ref_mem[i])
                else check_fail($sformatf("mem word %0d is %h, expected %h",
                                          i, u_mem.mem[i], ref_mem[i]));
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // tx flits against the reference stream
    always @(negedge clk_i) begin
        if (rst_ni && noc_tx_o) begin
            assert (exp_flits.size() != 0)
                else check_fail($sformatf("extra flit %h on the send link", noc_data_o));
            exp_w = exp_flits.pop_front();
            assert (noc_data_o == exp_w)
                else check_fail($sformatf("flit %h, expected %h", noc_data_o, exp_w));
        end
    end

    initial begin
        rst_ni     = 1'b0;
        noc_rx_i   = 1'b0;
        noc_data_i = '0;
        noc_ack_i  = 1'b1;
        cfg_i      = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ref_mem[i]   = next_rand();
            u_mem.mem[i] = ref_mem[i];
        end
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        @(negedge clk_i);
        assert (!noc_tx_o && mem_we_o == 4'b0 && !send_active_o && !recv_active_o)
            else check_fail("outputs not idle after reset");
        assert (noc_credit_o) else check_fail("credit low after reset");

        expect_send(32'h000, 32'd5, 32'h100, 32'd3);
        pulse_cfg(OP_SEND, 32'h000, 32'd5, 32'h100, 32'd3);
        run_send(1'b0);

        // random back-pressure
        expect_send(32'h040, 32'd7, 32'h180, 32'd4);
        pulse_cfg(OP_SEND, 32'h040, 32'd7, 32'h180, 32'd4);
        run_send(1'b1);

        make_payload(6);
        expect_receive(32'h200, 0, 6);
        fork
            send_packet(6);
            begin
                wait_available();
                assert (recv_flits_left_o == 32'd6)
                    else check_fail($sformatf("flits left %0d after size flit",
                                              recv_flits_left_o));
                pulse_cfg(OP_RECEIVE, 32'h200, 32'd6, '0, '0);
            end
        join
        assert (recv_flits_left_o == '0 && !recv_active_o)
            else check_fail("receive did not finish the packet");
        check_memory();

        // packet split over two buffers
        make_payload(6);
        expect_receive(32'h280, 0, 4);
        expect_receive(32'h2c0, 4, 2);
        fork
            send_packet(6);
            begin
                wait_available();
                pulse_cfg(OP_RECEIVE, 32'h280, 32'd4, '0, '0);
                wait_available();
                assert (recv_flits_left_o == 32'd2)
                    else check_fail($sformatf("flits left %0d after first buffer",
                                              recv_flits_left_o));
                pulse_cfg(OP_RECEIVE, 32'h2c0, 32'd2, '0, '0);
            end
        join
        check_memory();

        // both engines share the memory port
        make_payload(6);
        expect_receive(32'h300, 0, 6);
        expect_send(32'h000, 32'd10, 32'h0c0, 32'd6);
        pulse_cfg(OP_SEND, 32'h000, 32'd10, 32'h0c0, 32'd6);
        fork
            run_send(1'b1);
            send_packet(6);
            begin
                wait_available();
                pulse_cfg(OP_RECEIVE, 32'h300, 32'd6, '0, '0);
            end
        join
        check_memory();

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: compile.f
design/dmni_pkg.sv
design/dmni_send.sv
design/dmni_receive.sv
design/dmni_arbiter.sv
design/dmni_top.sv
dv/tb_mem.sv
dv/tb_dmni.sv

// File: run.sh
#!/bin/sh
# build the DMNI testbench with Verilator, run it and check the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f compile.f --top-module tb_dmni -o sim_dmni
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dmni)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1
